//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // one bit per stage: pc, if/id, id/ex, ex/mem, mem/wb, retire
  typedef logic [5:0] ctrl_vec_t;

  // bit positions inside ctrl_vec_t
  localparam int STG_PC     = 0;
  localparam int STG_IFID   = 1;
  localparam int STG_IDEX   = 2;
  localparam int STG_EXMEM  = 3;
  localparam int STG_MEMWB  = 4;
  localparam int STG_RETIRE = 5;

  // stall / flush pattern per hazard
  localparam ctrl_vec_t RAM_STALL        = 6'b001111;  // freeze up to ex/mem
  localparam ctrl_vec_t RAM_FLUSH        = 6'b010000;  // bubble into mem/wb
  localparam ctrl_vec_t TRAP_REDIR_STALL = 6'b000000;
  localparam ctrl_vec_t TRAP_REDIR_FLUSH = 6'b000011;  // kill fetch slot
  localparam ctrl_vec_t HALT_STALL       = 6'b111111;
  localparam ctrl_vec_t HALT_FLUSH       = 6'b001110;
  localparam ctrl_vec_t JUMP_STALL       = 6'b000000;
  localparam ctrl_vec_t JUMP_FLUSH       = 6'b000110;  // two younger slots
  localparam ctrl_vec_t MULDIV_STALL     = 6'b000111;
  localparam ctrl_vec_t MULDIV_FLUSH     = 6'b001000;
  localparam ctrl_vec_t LOADUSE_STALL    = 6'b000011;
  localparam ctrl_vec_t LOADUSE_FLUSH    = 6'b000100;  // bubble into id/ex
  localparam ctrl_vec_t RESET_FLUSH      = 6'b011111;

  localparam logic [31:0] RESET_PC = 32'h0000_1000;

  // iterative mul/div latency
  localparam int MULDIV_CYCLES = 4;
  localparam int MULDIV_CNT_W  = $clog2(MULDIV_CYCLES + 1);

  // token carried by if/id and id/ex
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } slot_t;

  // ex/mem and mem/wb token, tags mul/div ops
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        is_muldiv;
  } exec_slot_t;

  // csr map, byte offsets
  localparam logic [11:0] CSR_CTRL      = 12'h000;
  localparam logic [11:0] CSR_TRAPVEC   = 12'h004;
  localparam logic [11:0] CSR_STALLCNT  = 12'h008;
  localparam logic [11:0] CSR_FLUSHCNT  = 12'h00C;
  localparam logic [11:0] CSR_RETIRECNT = 12'h010;
  localparam int          CSR_HALT_BIT  = 0;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- source/pipe_ifs.sv
`default_nettype none

// stall/flush fan-out plus redirect info for the fetch side
interface pipe_ctrl_if;
  import pipe_pkg::*;

  ctrl_vec_t   stall;
  ctrl_vec_t   flush;
  logic        jump_valid;   // from ex, via top pins
  logic [31:0] jump_target;
  logic [31:0] trap_vec;     // csr trap vector

  modport ctrl (
    output stall,
    output flush
  );

  modport stage (
    input stall,
    input flush,
    input jump_valid,
    input jump_target,
    input trap_vec
  );
endinterface

// csr block <-> pipeline
interface csr_evt_if;
  logic        halt;
  logic [31:0] trap_vec;
  logic        stall_evt;   // single-cycle event strobes
  logic        flush_evt;
  logic        retire_evt;

  modport regs (
    output halt,
    output trap_vec,
    input  stall_evt,
    input  flush_evt,
    input  retire_evt
  );

  modport pipe (
    input  halt,
    input  trap_vec,
    output stall_evt,
    output flush_evt,
    output retire_evt
  );
endinterface

`default_nettype wire

//--- source/pipeline_control.sv
`default_nettype none

// pure combinational, later stage requests win
module pipeline_control (
  input  logic          rst,
  input  logic          ram_stall_if_i,   // fetch side ram busy
  input  logic          ram_stall_mem_i,  // data side ram busy
  input  logic          trap_redirect_i,  // trap taken, go to vector
  input  logic          trap_stall_i,     // csr access stall from wb
  input  logic          load_use_i,       // from id
  input  logic          muldiv_busy_i,    // from sequencer
  input  logic          halt_i,           // csr halt bit
  input  logic          jump_valid_i,     // branch resolved in ex
  pipe_ctrl_if.ctrl     ctrl
);
  import pipe_pkg::*;

  logic      ram_req;
  logic      halt_req;
  ctrl_vec_t stall_d;
  ctrl_vec_t flush_d;

  assign ram_req  = ram_stall_if_i | ram_stall_mem_i;  // both rams share one pattern
  assign halt_req = halt_i | trap_stall_i;             // csr halt behaves like trap stall

  always_comb begin
    if (rst) begin
      stall_d = '0;
      flush_d = RESET_FLUSH;  // empty every slot
    end else if (ram_req) begin
      stall_d = RAM_STALL;
      flush_d = RAM_FLUSH;
    end else if (trap_redirect_i) begin
      stall_d = TRAP_REDIR_STALL;
      flush_d = TRAP_REDIR_FLUSH;
    end else if (halt_req) begin
      stall_d = HALT_STALL;
      flush_d = HALT_FLUSH;
    end else if (jump_valid_i) begin
      stall_d = JUMP_STALL;
      flush_d = JUMP_FLUSH;
    end else if (muldiv_busy_i) begin
      stall_d = MULDIV_STALL;   // hold front end while ex iterates
      flush_d = MULDIV_FLUSH;
    end else if (load_use_i) begin
      stall_d = LOADUSE_STALL;
      flush_d = LOADUSE_FLUSH;
    end else begin
      stall_d = '0;  // normal flow
      flush_d = '0;
    end
  end

  assign ctrl.stall = stall_d;
  assign ctrl.flush = flush_d;

endmodule

`default_nettype wire

//--- source/stage_reg.sv
`default_nettype none

// one pipeline slot, payload must carry a valid field
module stage_reg #(
  parameter type payload_t = pipe_pkg::slot_t
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall_i,  // keep current slot
  input  logic     flush_i,  // insert bubble, wins over stall
  input  payload_t d_i,
  output payload_t q_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q_o <= '0;
    end else if (flush_i) begin
      q_o.valid <= 1'b0;  // bubble, rest of payload is don't care
    end else if (!stall_i) begin
      q_o <= d_i;
    end
    // stall: hold
  end

endmodule

`default_nettype wire

//--- source/pc_gen.sv
`default_nettype none

// fetch pc, feeds if/id
module pc_gen (
  input  logic           clk,
  input  logic           rst,
  pipe_ctrl_if.stage     ctrl,
  input  logic           trap_redirect_i,
  output pipe_pkg::slot_t pc_o
);
  import pipe_pkg::*;

  logic [31:0] pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (ctrl.flush[STG_PC] && trap_redirect_i) begin
      pc_q <= ctrl.trap_vec;      // trap entry
    end else if (ctrl.jump_valid) begin
      pc_q <= ctrl.jump_target;   // taken branch / jal
    end else if (!ctrl.stall[STG_PC]) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // fetched slot is dead in the cycle the pc is flushed
  always_comb begin
    pc_o.valid = ~ctrl.flush[STG_PC];
    pc_o.pc    = pc_q;
  end

endmodule

`default_nettype wire

//--- source/muldiv_sequencer.sv
`default_nettype none

// busy timer standing in for the iterative mul/div unit
module muldiv_sequencer (
  input  logic clk,
  input  logic rst,
  input  logic start_i,  // single-cycle start from ex
  output logic busy_o
);
  import pipe_pkg::*;

  logic [MULDIV_CNT_W-1:0] cnt_q;  // cycles left

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;  // running, new starts dropped
    end else if (start_i) begin
      cnt_q <= MULDIV_CNT_W'(MULDIV_CYCLES);
    end
  end

  // high for exactly MULDIV_CYCLES cycles after the start
  assign busy_o = (cnt_q != '0);

endmodule

`default_nettype wire

//--- source/hazard_csr.sv
`default_nettype none

// axi4-lite slave: halt, trap vector, event counters
module hazard_csr (
  input  logic        clk,
  input  logic        rst,
  input  logic [11:0] s_axi_awaddr_i,
  input  logic        s_axi_awvalid_i,
  output logic        s_axi_awready_o,
  input  logic [31:0] s_axi_wdata_i,
  input  logic [3:0]  s_axi_wstrb_i,
  input  logic        s_axi_wvalid_i,
  output logic        s_axi_wready_o,
  output logic [1:0]  s_axi_bresp_o,
  output logic        s_axi_bvalid_o,
  input  logic        s_axi_bready_i,
  input  logic [11:0] s_axi_araddr_i,
  input  logic        s_axi_arvalid_i,
  output logic        s_axi_arready_o,
  output logic [31:0] s_axi_rdata_o,
  output logic [1:0]  s_axi_rresp_o,
  output logic        s_axi_rvalid_o,
  input  logic        s_axi_rready_i,
  csr_evt_if.regs     evt
);
  import pipe_pkg::*;

  logic        aw_got;     // address latched, waiting for data
  logic        w_got;      // data latched, waiting for address
  logic [11:0] aw_addr_q;
  logic [31:0] w_data_q;
  logic [3:0]  w_strb_q;
  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  logic        wr_fire;    // both halves present this cycle
  logic [11:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;
  logic        halt_q;
  logic [31:0] trap_vec_q;
  logic [31:0] cnt_q [3];  // stall, flush, retire
  logic [2:0]  cnt_evt;
  logic [2:0]  cnt_clr;
  logic [31:0] rd_mux;

  assign aw_hs   = s_axi_awvalid_i & s_axi_awready_o;
  assign w_hs    = s_axi_wvalid_i & s_axi_wready_o;
  assign ar_hs   = s_axi_arvalid_i & s_axi_arready_o;
  assign wr_fire = (aw_got | aw_hs) & (w_got | w_hs) & ~s_axi_bvalid_o;

  // take the latched half if it came first, else the live bus
  assign wr_addr = aw_got ? aw_addr_q : s_axi_awaddr_i;
  assign wr_data = w_got ? w_data_q : s_axi_wdata_i;
  assign wr_strb = w_got ? w_strb_q : s_axi_wstrb_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      s_axi_awready_o <= 1'b0;
      s_axi_wready_o  <= 1'b0;
      s_axi_bvalid_o  <= 1'b0;
      aw_got          <= 1'b0;
      w_got           <= 1'b0;
    end else begin
      // one-cycle ready pulse, blocked while a response is pending
      s_axi_awready_o <= s_axi_awvalid_i & ~s_axi_awready_o & ~aw_got & ~s_axi_bvalid_o;
      s_axi_wready_o  <= s_axi_wvalid_i & ~s_axi_wready_o & ~w_got & ~s_axi_bvalid_o;
      aw_got          <= ~wr_fire & (aw_got | aw_hs);
      w_got           <= ~wr_fire & (w_got | w_hs);
      if (wr_fire) begin
        s_axi_bvalid_o <= 1'b1;
      end else if (s_axi_bready_i) begin
        s_axi_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) aw_addr_q <= s_axi_awaddr_i;
    if (w_hs) begin
      w_data_q <= s_axi_wdata_i;
      w_strb_q <= s_axi_wstrb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q     <= 1'b0;
      trap_vec_q <= RESET_PC;
    end else if (wr_fire) begin
      case (wr_addr)
        CSR_CTRL: if (wr_strb[0]) halt_q <= wr_data[CSR_HALT_BIT];
        CSR_TRAPVEC: begin
          for (int b = 0; b < 4; b++) begin
            if (wr_strb[b]) trap_vec_q[8*b +: 8] <= wr_data[8*b +: 8];  // byte lanes
          end
        end
        default: ;  // counters handled below, rest ignored
      endcase
    end
  end

  assign cnt_evt    = {evt.retire_evt, evt.flush_evt, evt.stall_evt};
  assign cnt_clr[0] = wr_fire & wr_data[0] & (wr_addr == CSR_STALLCNT);
  assign cnt_clr[1] = wr_fire & wr_data[0] & (wr_addr == CSR_FLUSHCNT);
  assign cnt_clr[2] = wr_fire & wr_data[0] & (wr_addr == CSR_RETIRECNT);

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (rst || cnt_clr[i]) begin
        cnt_q[i] <= '0;
      end else if (cnt_evt[i] && cnt_q[i] != '1) begin
        cnt_q[i] <= cnt_q[i] + 32'd1;  // saturates at all ones
      end
    end
  end

  always_comb begin
    case (s_axi_araddr_i)
      CSR_CTRL:      rd_mux = 32'(halt_q) << CSR_HALT_BIT;
      CSR_TRAPVEC:   rd_mux = trap_vec_q;
      CSR_STALLCNT:  rd_mux = cnt_q[0];
      CSR_FLUSHCNT:  rd_mux = cnt_q[1];
      CSR_RETIRECNT: rd_mux = cnt_q[2];
      default:       rd_mux = '0;  // unmapped reads zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s_axi_arready_o <= 1'b0;
      s_axi_rvalid_o  <= 1'b0;
    end else begin
      s_axi_arready_o <= s_axi_arvalid_i & ~s_axi_arready_o & ~s_axi_rvalid_o;
      if (ar_hs) begin
        s_axi_rvalid_o <= 1'b1;
      end else if (s_axi_rready_i) begin
        s_axi_rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) s_axi_rdata_o <= rd_mux;  // sampled at address accept
  end

  assign s_axi_bresp_o = AXI_RESP_OKAY;
  assign s_axi_rresp_o = AXI_RESP_OKAY;
  assign evt.halt      = halt_q;
  assign evt.trap_vec  = trap_vec_q;

endmodule

`default_nettype wire

//--- source/pipe_ctrl_top.sv
`default_nettype none

module pipe_ctrl_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                ram_stall_if_i,
  input  logic                ram_stall_mem_i,
  input  logic                trap_redirect_i,
  input  logic                trap_stall_i,
  input  logic                load_use_i,
  input  logic                jump_valid_i,
  input  logic [31:0]         jump_target_i,
  input  logic                muldiv_start_i,
  input  logic [11:0]         s_axi_awaddr_i,
  input  logic                s_axi_awvalid_i,
  output logic                s_axi_awready_o,
  input  logic [31:0]         s_axi_wdata_i,
  input  logic [3:0]          s_axi_wstrb_i,
  input  logic                s_axi_wvalid_i,
  output logic                s_axi_wready_o,
  output logic [1:0]          s_axi_bresp_o,
  output logic                s_axi_bvalid_o,
  input  logic                s_axi_bready_i,
  input  logic [11:0]         s_axi_araddr_i,
  input  logic                s_axi_arvalid_i,
  output logic                s_axi_arready_o,
  output logic [31:0]         s_axi_rdata_o,
  output logic [1:0]          s_axi_rresp_o,
  output logic                s_axi_rvalid_o,
  input  logic                s_axi_rready_i,
  output pipe_pkg::ctrl_vec_t stall_o,
  output pipe_pkg::ctrl_vec_t flush_o,
  output logic                retire_valid_o,
  output logic [31:0]         retire_pc_o
);
  import pipe_pkg::*;

  pipe_ctrl_if ctrl_if ();
  csr_evt_if   evt_if ();

  logic       muldiv_busy;
  slot_t      pc_slot;   // fetch output
  slot_t      ifid_q;
  slot_t      idex_q;
  exec_slot_t exmem_d;
  exec_slot_t exmem_q;
  exec_slot_t memwb_q;

  assign ctrl_if.jump_valid  = jump_valid_i;
  assign ctrl_if.jump_target = jump_target_i;
  assign ctrl_if.trap_vec    = evt_if.trap_vec;

  pipeline_control u_ctrl (
    .rst             (rst),
    .ram_stall_if_i  (ram_stall_if_i),
    .ram_stall_mem_i (ram_stall_mem_i),
    .trap_redirect_i (trap_redirect_i),
    .trap_stall_i    (trap_stall_i),
    .load_use_i      (load_use_i),
    .muldiv_busy_i   (muldiv_busy),
    .halt_i          (evt_if.halt),
    .jump_valid_i    (jump_valid_i),
    .ctrl            (ctrl_if.ctrl)
  );

  pc_gen u_pc (
    .clk             (clk),
    .rst             (rst),
    .ctrl            (ctrl_if.stage),
    .trap_redirect_i (trap_redirect_i),
    .pc_o            (pc_slot)
  );

  muldiv_sequencer u_muldiv (
    .clk     (clk),
    .rst     (rst),
    .start_i (muldiv_start_i),
    .busy_o  (muldiv_busy)
  );

  stage_reg #(.payload_t(slot_t)) u_if_id (
    .clk (clk), .rst (rst),
    .stall_i (ctrl_if.stall[STG_IFID]), .flush_i (ctrl_if.flush[STG_IFID]),
    .d_i (pc_slot), .q_o (ifid_q)
  );

  stage_reg #(.payload_t(slot_t)) u_id_ex (
    .clk (clk), .rst (rst),
    .stall_i (ctrl_if.stall[STG_IDEX]), .flush_i (ctrl_if.flush[STG_IDEX]),
    .d_i (ifid_q), .q_o (idex_q)
  );

  // tag the op leaving id/ex when ex kicks off the mul/div unit
  always_comb begin
    exmem_d.valid     = idex_q.valid;
    exmem_d.pc        = idex_q.pc;
    exmem_d.is_muldiv = muldiv_start_i & idex_q.valid;
  end

  stage_reg #(.payload_t(exec_slot_t)) u_ex_mem (
    .clk (clk), .rst (rst),
    .stall_i (ctrl_if.stall[STG_EXMEM]), .flush_i (ctrl_if.flush[STG_EXMEM]),
    .d_i (exmem_d), .q_o (exmem_q)
  );

  stage_reg #(.payload_t(exec_slot_t)) u_mem_wb (
    .clk (clk), .rst (rst),
    .stall_i (ctrl_if.stall[STG_MEMWB]), .flush_i (ctrl_if.flush[STG_MEMWB]),
    .d_i (exmem_q), .q_o (memwb_q)
  );

  assign stall_o        = ctrl_if.stall;
  assign flush_o        = ctrl_if.flush;
  assign retire_valid_o = memwb_q.valid & ~ctrl_if.stall[STG_RETIRE];  // wb not frozen
  assign retire_pc_o    = memwb_q.pc;

  // counter strobes, reset flush not counted
  assign evt_if.stall_evt  = |ctrl_if.stall;
  assign evt_if.flush_evt  = (|ctrl_if.flush) & ~rst;
  assign evt_if.retire_evt = retire_valid_o;

  hazard_csr u_csr (
    .clk             (clk),
    .rst             (rst),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .evt             (evt_if.regs)
  );

endmodule

`default_nettype wire

//--- tests/pipe_ctrl_tb.sv
`default_nettype none

module pipe_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import pipe_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRV_DLY    = 2;   // input skew after rising edge
  localparam int MAX_LINES  = 64;

  logic        clk;
  logic        rst;
  logic        ram_stall_if, ram_stall_mem, trap_redirect, trap_stall;
  logic        load_use, jump_valid, muldiv_start;
  logic [31:0] jump_target;
  logic [11:0] s_axi_awaddr, s_axi_araddr;
  logic        s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready;
  logic [31:0] s_axi_wdata;
  logic [3:0]  s_axi_wstrb;
  logic        s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready, s_axi_rvalid;
  logic [1:0]  s_axi_bresp, s_axi_rresp;
  logic [31:0] s_axi_rdata;
  ctrl_vec_t   stall_o, flush_o;
  logic        retire_valid;
  logic [31:0] retire_pc;

  logic [79:0] vec_mem [MAX_LINES];  // kind, req, value, expected
  int          n_lines = 0;
  int          err_cnt = 0;

  // observed by the monitor
  slot_t       retq [$];
  slot_t       expq [$];
  logic [31:0] seen [3];   // stall, flush, retire events
  logic [31:0] snap [3];   // copy taken at read address accept
  int          cyc;        // cycles since reset release
  int          md_cnt;     // cycles showing the mul/div pattern

  pipe_ctrl_top dut0 (
    .clk (clk), .rst (rst),
    .ram_stall_if_i (ram_stall_if), .ram_stall_mem_i (ram_stall_mem),
    .trap_redirect_i (trap_redirect), .trap_stall_i (trap_stall),
    .load_use_i (load_use), .jump_valid_i (jump_valid),
    .jump_target_i (jump_target), .muldiv_start_i (muldiv_start),
    .s_axi_awaddr_i (s_axi_awaddr), .s_axi_awvalid_i (s_axi_awvalid),
    .s_axi_awready_o (s_axi_awready), .s_axi_wdata_i (s_axi_wdata),
    .s_axi_wstrb_i (s_axi_wstrb), .s_axi_wvalid_i (s_axi_wvalid),
    .s_axi_wready_o (s_axi_wready), .s_axi_bresp_o (s_axi_bresp),
    .s_axi_bvalid_o (s_axi_bvalid), .s_axi_bready_i (s_axi_bready),
    .s_axi_araddr_i (s_axi_araddr), .s_axi_arvalid_i (s_axi_arvalid),
    .s_axi_arready_o (s_axi_arready), .s_axi_rdata_o (s_axi_rdata),
    .s_axi_rresp_o (s_axi_rresp), .s_axi_rvalid_o (s_axi_rvalid),
    .s_axi_rready_i (s_axi_rready),
    .stall_o (stall_o), .flush_o (flush_o),
    .retire_valid_o (retire_valid), .retire_pc_o (retire_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // sample at falling edge, inputs settled since rise + 2ns
  always @(negedge clk) begin
    slot_t s;
    if (rst) begin
      retq.delete();
      for (int i = 0; i < 3; i++) seen[i] = '0;
      cyc    = 0;
      md_cnt = 0;
    end else begin
      if (s_axi_arvalid && s_axi_arready) snap = seen;  // dut sees events up to here
      if (|stall_o) seen[0] = seen[0] + 1;
      if (|flush_o) seen[1] = seen[1] + 1;
      if (retire_valid) begin
        seen[2] = seen[2] + 1;
        s.valid = 1'b1;
        s.pc    = retire_pc;
        retq.push_back(s);
      end
      if (stall_o == MULDIV_STALL) md_cnt++;
      cyc++;
    end
  end

  initial begin
    wait (n_lines != 0);
    #((n_lines * 200 + 5) * CLK_PERIOD);
    $display("Timeout: the run did not finish in %0d cycles", n_lines * 200 + 5);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  task automatic report_error(input string msg);
    err_cnt++;
    $display("** Error at %0d ns: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_vec(input string what, input ctrl_vec_t got, input ctrl_vec_t exp);
    if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_pc(input string what, input slot_t got, input slot_t exp);
    if (got !== exp) begin
      report_error($sformatf("%s got valid %b pc %h expected valid %b pc %h",
                             what, got.valid, got.pc, exp.valid, exp.pc));
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic drive_idle();
    ram_stall_if  = 1'b0;
    ram_stall_mem = 1'b0;
    trap_redirect = 1'b0;
    trap_stall    = 1'b0;
    load_use      = 1'b0;
    jump_valid    = 1'b0;
    muldiv_start  = 1'b0;
    jump_target   = '0;
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    drive_idle();
    expq.delete();
    repeat (5) next_cycle();
    rst = 1'b0;  // cycle 0 starts here
  endtask

  // expected retire run, consecutive words
  function automatic void push_run(input logic [31:0] start, input int n);
    slot_t s;
    for (int i = 0; i < n; i++) begin
      s.valid = 1'b1;
      s.pc    = start + 32'(4 * i);
      expq.push_back(s);
    end
  endfunction

  task automatic compare_retires();
    while (retq.size() < expq.size()) @(posedge clk);
    #DRV_DLY;
    for (int i = 0; i < expq.size(); i++) check_pc($sformatf("retire %0d", i), retq[i], expq[i]);
  endtask

  // aw and w in random order and spacing
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
    int unsigned aw_gap;
    int unsigned w_gap;
    aw_gap = $urandom_range(2, 0);
    w_gap  = $urandom_range(2, 0);
    fork
      begin
        repeat (aw_gap) next_cycle();
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        do @(negedge clk); while (!s_axi_awready);
        next_cycle();
        s_axi_awvalid = 1'b0;
      end
      begin
        repeat (w_gap) next_cycle();
        s_axi_wdata  = data;
        s_axi_wstrb  = 4'hF;
        s_axi_wvalid = 1'b1;
        do @(negedge clk); while (!s_axi_wready);
        next_cycle();
        s_axi_wvalid = 1'b0;
      end
    join
    s_axi_bready = 1'b1;
    do @(negedge clk); while (!s_axi_bvalid);
    check_word("bresp", 32'(s_axi_bresp), 32'(AXI_RESP_OKAY));
    next_cycle();
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do @(negedge clk); while (!s_axi_arready);
    next_cycle();
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    do @(negedge clk); while (!s_axi_rvalid);
    data = s_axi_rdata;
    check_word("rresp", 32'(s_axi_rresp), 32'(AXI_RESP_OKAY));
    next_cycle();
    s_axi_rready = 1'b0;
  endtask

  // req bits: ram if, ram mem, trap redir, trap stall, load-use, jump, mul/div
  task automatic apply_priority(input logic [7:0] req, input logic [31:0] value,
                                input logic [31:0] expv);
    if (req[6]) begin
      muldiv_start = 1'b1;  // busy shows up one cycle later
      next_cycle();
      muldiv_start = 1'b0;
    end
    ram_stall_if  = req[0];
    ram_stall_mem = req[1];
    trap_redirect = req[2];
    trap_stall    = req[3];
    load_use      = req[4];
    jump_valid    = req[5];
    jump_target   = value;
    @(negedge clk);
    check_vec("stall_o", stall_o, expv[11:6]);
    check_vec("flush_o", flush_o, expv[5:0]);
    next_cycle();
    drive_idle();
    if (req[6]) repeat (MULDIV_CYCLES + 1) next_cycle();
    repeat ($urandom_range(3, 0)) next_cycle();
  endtask

  task automatic jump_redirect(input int k, input logic [31:0] target,
                               input logic [31:0] jump_pc);
    reset_dut();
    repeat (k) next_cycle();
    jump_valid  = 1'b1;
    jump_target = target;
    next_cycle();
    drive_idle();
    push_run(RESET_PC, int'((jump_pc - RESET_PC) >> 2) + 1);
    push_run(target, 3);  // jump + 4 and + 8 never show up
    compare_retires();
  endtask

  task automatic trap_vector(input logic [31:0] vec);
    int c;
    reset_dut();
    axi_write(CSR_TRAPVEC, vec);
    repeat ($urandom_range(3, 0)) next_cycle();
    c = cyc;                // pc holds RESET_PC + 4c now
    trap_redirect = 1'b1;
    next_cycle();
    trap_redirect = 1'b0;
    push_run(RESET_PC, c);  // only the fetch slot dies
    push_run(vec, 2);
    compare_retires();
  endtask

  task automatic halt_freeze(input int hold, input logic [31:0] ctrl_exp);
    int          n;
    logic [31:0] d;
    reset_dut();
    axi_write(CSR_CTRL, 32'h1);
    n = retq.size();
    repeat (hold) begin
      @(negedge clk);
      check_word("retire_valid_o while halted", 32'(retire_valid), 32'h0);
    end
    next_cycle();
    axi_read(CSR_CTRL, d);
    check_word("ctrl readback", d, ctrl_exp);
    check_word("retires while halted", 32'(retq.size() - n), 32'h0);
    axi_write(CSR_CTRL, 32'h0);
    while (retq.size() == n) @(posedge clk);  // flow resumes
    #DRV_DLY;
  endtask

  task automatic counter_check(input logic [31:0] target);
    logic [31:0] d;
    logic [11:0] addrs [3];
    addrs = '{CSR_STALLCNT, CSR_FLUSHCNT, CSR_RETIRECNT};
    reset_dut();
    repeat (2) next_cycle();
    load_use = 1'b1;
    next_cycle();
    load_use = 1'b0;
    repeat ($urandom_range(3, 0)) next_cycle();
    jump_valid  = 1'b1;
    jump_target = target;
    next_cycle();
    drive_idle();
    ram_stall_mem = 1'b1;
    repeat (2) next_cycle();
    ram_stall_mem = 1'b0;
    muldiv_start  = 1'b1;
    next_cycle();
    muldiv_start  = 1'b0;
    repeat (MULDIV_CYCLES + 4) next_cycle();
    for (int i = 0; i < 3; i++) begin
      axi_read(addrs[i], d);
      check_word($sformatf("counter at %h", addrs[i]), d, snap[i]);
    end
    // pipeline idle, stall and flush stay put
    for (int i = 0; i < 2; i++) begin
      axi_write(addrs[i], 32'h1);
      axi_read(addrs[i], d);
      check_word($sformatf("cleared counter at %h", addrs[i]), d, 32'h0);
    end
    axi_write(CSR_CTRL, 32'h1);  // halt so nothing retires
    axi_write(CSR_RETIRECNT, 32'h1);
    axi_read(CSR_RETIRECNT, d);
    check_word("cleared retire counter", d, 32'h0);
    axi_write(CSR_CTRL, 32'h0);
  endtask

  initial begin
    logic [79:0] entry;
    logic [7:0]  kind;
    logic [7:0]  req;
    logic [31:0] value;
    logic [31:0] expv;
    void'($urandom(32'hc66224e6));
    rst           = 1'b1;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    drive_idle();
    for (int i = 0; i < MAX_LINES; i++) vec_mem[i] = '1;
    $readmemh("tests/pipe_testdata.txt", vec_mem);
    while (n_lines < MAX_LINES && vec_mem[n_lines][79:72] !== 8'hFF) n_lines++;
    reset_dut();
    for (int i = 0; i < n_lines; i++) begin
      entry = vec_mem[i];
      kind  = entry[79:72];
      req   = entry[71:64];
      value = entry[63:32];
      expv  = entry[31:0];
      case (kind)
        8'h01: apply_priority(req, value, expv);
        8'h02: begin
          reset_dut();
          push_run(expv, int'(value));
          compare_retires();
        end
        8'h03: jump_redirect(int'(req), value, expv);
        8'h04: begin
          reset_dut();
          repeat (int'(req)) next_cycle();
          load_use = 1'b1;
          repeat (int'(value)) next_cycle();
          load_use = 1'b0;
          push_run(RESET_PC, int'(expv));  // no repeat, no loss
          compare_retires();
        end
        8'h05: begin
          reset_dut();
          repeat (int'(req)) next_cycle();
          muldiv_start = 1'b1;
          next_cycle();
          muldiv_start = 1'b0;
          push_run(RESET_PC, int'(value));
          compare_retires();
          check_word("mul/div stall cycles", 32'(md_cnt), expv);
        end
        8'h06: trap_vector(value);
        8'h07: halt_freeze(int'(value), expv);
        8'h08: counter_check(value);
        default: report_error($sformatf("unknown step kind %h on data line %0d", kind, i));
      endcase
    end
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/pipe_testdata.txt
// kind(2) req(2) value(8) expected(8), one step per line
// kind 01: req bits 0 ram if, 1 ram mem, 2 trap redir, 3 trap stall, 4 load-use, 5 jump, 6 mul/div
010100000000000003D0
010200000000000003D0
013F00002000000003D0
013C0000200000000003
01380000200000000FCE
01300000200000000006
015000000000000001C8
01700000200000000006
01480000000000000FCE
011000000000000000C4
01000000000000000000
// 02 flow: value retire count, expected first pc
02000000000C00001000
// 03 jump: req cycle, value target, expected pc of the jump slot
03060000400000001010
// 04 load-use: req cycle, value hold cycles, expected retire count
04050000000200000010
// 05 mul/div: req cycle, value retire count, expected stall cycles
05040000000C00000004
// 06 trap vector, 07 halt hold cycles and ctrl readback, 08 counters with jump target
06000000800000008000
07000000000800000001
08000000300000000000

//--- tb.f
source/pipe_pkg.sv
source/pipe_ifs.sv
source/pipeline_control.sv
source/stage_reg.sv
source/pc_gen.sv
source/muldiv_sequencer.sv
source/hazard_csr.sv
source/pipe_ctrl_top.sv
tests/pipe_ctrl_tb.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - source/pipe_pkg.sv
  - source/pipe_ifs.sv
  - source/pipeline_control.sv
  - source/stage_reg.sv
  - source/pc_gen.sv
  - source/muldiv_sequencer.sv
  - source/hazard_csr.sv
  - source/pipe_ctrl_top.sv
  - target: test
    files:
      - tests/pipe_ctrl_tb.sv
